// File: flist.f
hdl/fetch_pkg.sv
hdl/pc_redirect.sv
hdl/prog_loader.sv
hdl/fetch_core.sv
hdl/inst_mem.sv
hdl/fetch_top.sv
bench/fetch_checker.sv
bench/tb_fetch.sv

// File: Bender.yml
package:
  name: fetch_stage

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/pc_redirect.sv
      - hdl/prog_loader.sv
      - hdl/fetch_core.sv
      - hdl/inst_mem.sv
      - hdl/fetch_top.sv
  - target: simulation
    files:
      - bench/fetch_checker.sv
      - bench/tb_fetch.sv

// File: bench/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

   import fetch_pkg::*;

   localparam int CLK_PERIOD  = 40;
   localparam int LOAD_WORDS  = 64;
   localparam int RAND_CYCLES = 2000;
   // Word count plus reset, entry and exit overhead
   localparam int LOAD_CYCLES = LOAD_WORDS + 16;
   localparam int TIMEOUT_NS  = (LOAD_CYCLES + RAND_CYCLES) * CLK_PERIOD * 2;

   logic               clk;
   logic               rstn;
   logic               pause_i;
   logic               branch_i;
   logic               zero_i;
   logic               jump_i;
   logic               jalr_i;
   logic [XLEN-1:0]    alu_result_i;
   logic [XLEN-1:0]    imm32_i;
   logic [XLEN-1:0]    mem_pc_i;
   logic               upg_rst_i;
   logic               upg_wen_i;
   logic [IMEM_AW-1:0] upg_adr_i;
   logic [XLEN-1:0]    upg_dat_i;
   logic               upg_done_i;
   logic [XLEN-1:0]    inst_o;
   logic [XLEN-1:0]    pc_o;
   logic [XLEN-1:0]    pc4_o;
   logic               flush_o;
   logic               loading_o;
   int                 checks;
   int                 errors;
   integer             seed;

   always #(CLK_PERIOD / 2) clk = ~clk;

   fetch_top u_fetch_top (
      .clk (clk), .rstn (rstn), .pause_i (pause_i), .branch_i (branch_i),
      .zero_i (zero_i), .jump_i (jump_i), .jalr_i (jalr_i),
      .alu_result_i (alu_result_i), .imm32_i (imm32_i), .mem_pc_i (mem_pc_i),
      .upg_rst_i (upg_rst_i), .upg_wen_i (upg_wen_i), .upg_adr_i (upg_adr_i),
      .upg_dat_i (upg_dat_i), .upg_done_i (upg_done_i), .inst_o (inst_o),
      .pc_o (pc_o), .pc4_o (pc4_o), .flush_o (flush_o), .loading_o (loading_o)
   );

   fetch_checker u_fetch_checker (
      .clk (clk), .rstn (rstn), .pause_i (pause_i), .branch_i (branch_i),
      .zero_i (zero_i), .jump_i (jump_i), .jalr_i (jalr_i),
      .alu_result_i (alu_result_i), .imm32_i (imm32_i), .mem_pc_i (mem_pc_i),
      .upg_rst_i (upg_rst_i), .upg_wen_i (upg_wen_i), .upg_adr_i (upg_adr_i),
      .upg_dat_i (upg_dat_i), .upg_done_i (upg_done_i), .inst_i (inst_o),
      .pc_i (pc_o), .pc4_i (pc4_o), .flush_i (flush_o), .loading_i (loading_o),
      .checks_o (checks), .errors_o (errors)
   );

   ////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////

   // Sampled mid-cycle where loading_o is settled
   task automatic wait_loading(input logic level);
      @(negedge clk);
      while (loading_o !== level) begin
         @(negedge clk);
      end
   endtask

   // Upgrade reset low enters load and done high leaves it
   // Pipeline strobes keep toggling so load must win over redirect
   task automatic load_program();
      @(posedge clk);
      upg_rst_i <= 1'b0;
      wait_loading(1'b1);
      for (int i = 0; i < LOAD_WORDS; i++) begin
         @(posedge clk);
         upg_wen_i <= 1'b1;
         upg_adr_i <= i[IMEM_AW-1:0];
         upg_dat_i <= $random(seed);
         randomize_pipe_inputs();
      end
      clear_strobes();
      upg_wen_i  <= 1'b0;
      @(posedge clk);
      // Stays high so the loader never re-enters load
      upg_done_i <= 1'b1;
      wait_loading(1'b0);
   endtask

   // Targets kept word aligned and under 256 bytes
   task automatic randomize_pipe_inputs();
      pause_i      <= ({$random(seed)} % 100) < 20;
      branch_i     <= ({$random(seed)} % 100) < 10;
      jump_i       <= ({$random(seed)} % 100) < 10;
      jalr_i       <= ({$random(seed)} % 100) < 10;
      zero_i       <= ({$random(seed)} % 2) == 1;
      mem_pc_i     <= $random(seed) & 32'h0000_007c;
      imm32_i      <= $random(seed) & 32'h0000_007c;
      alu_result_i <= $random(seed) & 32'h0000_00fc;
   endtask

   task automatic drive_random_cycle();
      @(posedge clk);
      randomize_pipe_inputs();
   endtask

   task automatic clear_strobes();
      @(posedge clk);
      pause_i  <= 1'b0;
      branch_i <= 1'b0;
      jump_i   <= 1'b0;
      jalr_i   <= 1'b0;
   endtask

   initial begin
      seed         = 32'h9a6d;
      clk          = 1'b0;
      rstn         = 1'b0;
      pause_i      = 1'b0;
      branch_i     = 1'b0;
      zero_i       = 1'b0;
      jump_i       = 1'b0;
      jalr_i       = 1'b0;
      alu_result_i = '0;
      imm32_i      = '0;
      mem_pc_i     = '0;
      // Upgrade reset held so the loader idles in run
      upg_rst_i    = 1'b1;
      upg_wen_i    = 1'b0;
      upg_adr_i    = '0;
      upg_dat_i    = '0;
      upg_done_i   = 1'b0;
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      load_program();
      repeat (RAND_CYCLES) drive_random_cycle();
      clear_strobes();
      repeat (4) @(posedge clk);
      // Checker finished its last compare at the previous falling edge
      @(negedge clk);
      @(posedge clk);
      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: bench/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
   input  logic                          clk,
   input  logic                          rstn,
   // Stimulus seen at the DUT inputs
   input  logic                          pause_i,
   input  logic                          branch_i,
   input  logic                          zero_i,
   input  logic                          jump_i,
   input  logic                          jalr_i,
   input  logic [fetch_pkg::XLEN-1:0]    alu_result_i,
   input  logic [fetch_pkg::XLEN-1:0]    imm32_i,
   input  logic [fetch_pkg::XLEN-1:0]    mem_pc_i,
   input  logic                          upg_rst_i,
   input  logic                          upg_wen_i,
   input  logic [fetch_pkg::IMEM_AW-1:0] upg_adr_i,
   input  logic [fetch_pkg::XLEN-1:0]    upg_dat_i,
   input  logic                          upg_done_i,
   // DUT outputs under test
   input  logic [fetch_pkg::XLEN-1:0]    inst_i,
   input  logic [fetch_pkg::XLEN-1:0]    pc_i,
   input  logic [fetch_pkg::XLEN-1:0]    pc4_i,
   input  logic                          flush_i,
   input  logic                          loading_i,
   // Running totals
   output int                            checks_o,
   output int                            errors_o
);

   import fetch_pkg::*;

   // Reference state, valid for the cycle being sampled
   logic [XLEN-1:0]    m_mem [2**IMEM_AW];
   logic [XLEN-1:0]    m_pc;
   loader_state_e      m_state;
   logic               m_rd_valid;
   logic               m_we;
   logic [IMEM_AW-1:0] m_waddr;
   logic [XLEN-1:0]    m_wdata;
   logic               m_valid = 1'b0;
   int                 n_checks = 0;
   int                 n_errors = 0;

   assign checks_o = n_checks;
   assign errors_o = n_errors;

   // Program RAM is blank at time zero
   initial begin
      for (int i = 0; i < 2**IMEM_AW; i++) begin
         m_mem[i] = '0;
      end
   end

   ////////////////////////////////
   // Reference rules
   ////////////////////////////////

   // Taken branch, then jump, then register jump
   function automatic pc_sel_e expected_sel();
      if (branch_i && zero_i) begin
         return PC_BRANCH;
      end
      if (jump_i) begin
         return PC_JUMP;
      end
      if (jalr_i) begin
         return PC_JALR;
      end
      return PC_SEQ;
   endfunction

   // Label of the behavior exercised this cycle
   function automatic string cycle_kind(input pc_sel_e sel, input logic loading);
      if (!m_rd_valid) begin
         return "reset";
      end
      if (loading) begin
         return "load";
      end
      if (sel != PC_SEQ) begin
         return pause_i ? "redirect_pause" : "redirect";
      end
      return pause_i ? "pause" : "sequential";
   endfunction

   task automatic check_value(input string kind, input string name,
                              input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
      n_checks++;
      if (actual !== expected) begin
         n_errors++;
         $display("Error: %s %s expected %h actual %h at %0t ns",
                  kind, name, expected, actual, $time);
      end
   endtask

   ////////////////////////////////
   // Compare, then step the model
   ////////////////////////////////

   // Mid-cycle sampling, inputs and outputs both settled
   always @(negedge clk) begin : model_step
      pc_sel_e         sel;
      logic [XLEN-1:0] target;
      logic            loading;
      logic [XLEN-1:0] exp_inst;
      string           kind;

      sel     = expected_sel();
      target  = (sel == PC_JALR) ? alu_result_i : mem_pc_i + imm32_i;
      loading = (m_state == LD_LOAD);
      kind    = cycle_kind(sel, loading);
      exp_inst = (loading || !m_rd_valid) ? NOP_INST : m_mem[m_pc[IMEM_AW+1:2]];

      if (m_valid) begin
         check_value(kind, "pc_o", m_pc, pc_i);
         check_value(kind, "pc4_o", m_pc + 32'd4, pc4_i);
         check_value(kind, "loading_o", loading, loading_i);
         check_value(kind, "flush_o", (sel != PC_SEQ) && !loading, flush_i);
         check_value(kind, "inst_o", exp_inst, inst_i);
      end

      if (!rstn) begin
         m_pc       = RESET_PC;
         m_state    = LD_RUN;
         m_rd_valid = 1'b0;
         m_we       = 1'b0;
         m_valid    = 1'b1;
      end else begin
         // Write lands one edge after the sampled strobe
         if (m_we) begin
            m_mem[m_waddr] = m_wdata;
         end
         m_we    = loading && upg_wen_i;
         m_waddr = upg_adr_i;
         m_wdata = upg_dat_i;
         // Load, redirect, pause, sequential
         if (loading) begin
            m_pc = RESET_PC;
         end else if (sel != PC_SEQ) begin
            m_pc = target;
         end else if (!pause_i) begin
            m_pc = m_pc + 32'd4;
         end
         if (!loading && !upg_rst_i && !upg_done_i) begin
            m_state = LD_LOAD;
         end else if (loading && (upg_done_i || upg_rst_i)) begin
            m_state = LD_RUN;
         end
         m_rd_valid = 1'b1;
      end
   end

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
   input  logic                          clk,
   input  logic                          rstn,
   // EX/MEM stage
   input  logic                          pause_i,
   input  logic                          branch_i,
   input  logic                          zero_i,
   input  logic                          jump_i,
   input  logic                          jalr_i,
   input  logic [fetch_pkg::XLEN-1:0]    alu_result_i,
   input  logic [fetch_pkg::XLEN-1:0]    imm32_i,
   input  logic [fetch_pkg::XLEN-1:0]    mem_pc_i,
   // Upgrade port
   input  logic                          upg_rst_i,
   input  logic                          upg_wen_i,
   input  logic [fetch_pkg::IMEM_AW-1:0] upg_adr_i,
   input  logic [fetch_pkg::XLEN-1:0]    upg_dat_i,
   input  logic                          upg_done_i,
   // To decode
   output logic [fetch_pkg::XLEN-1:0]    inst_o,
   output logic [fetch_pkg::XLEN-1:0]    pc_o,
   output logic [fetch_pkg::XLEN-1:0]    pc4_o,
   output logic                          flush_o,
   output logic                          loading_o
);

   import fetch_pkg::*;

   ///////////////////////////////
   // Internal nets
   ///////////////////////////////

   pc_sel_e            pc_sel;
   logic [XLEN-1:0]    redirect_target;
   logic               load_active;
   logic               imem_we;
   logic [IMEM_AW-1:0] imem_waddr;
   logic [XLEN-1:0]    imem_wdata;
   logic [IMEM_AW-1:0] imem_raddr;
   logic [XLEN-1:0]    imem_rdata;

   // Redirect resolution
   pc_redirect u_pc_redirect (
      .branch_i     (branch_i),
      .zero_i       (zero_i),
      .jump_i       (jump_i),
      .jalr_i       (jalr_i),
      .alu_result_i (alu_result_i),
      .imm32_i      (imm32_i),
      .mem_pc_i     (mem_pc_i),
      .pc_sel_o     (pc_sel),
      .target_o     (redirect_target)
   );

   // Upgrade loader
   prog_loader u_prog_loader (
      .clk           (clk),
      .rstn          (rstn),
      .upg_rst_i     (upg_rst_i),
      .upg_wen_i     (upg_wen_i),
      .upg_done_i    (upg_done_i),
      .upg_adr_i     (upg_adr_i),
      .upg_dat_i     (upg_dat_i),
      .load_active_o (load_active),
      .imem_we_o     (imem_we),
      .imem_waddr_o  (imem_waddr),
      .imem_wdata_o  (imem_wdata)
   );

   // PC and instruction path
   fetch_core u_fetch_core (
      .clk           (clk),
      .rstn          (rstn),
      .pause_i       (pause_i),
      .load_active_i (load_active),
      .pc_sel_i      (pc_sel),
      .target_i      (redirect_target),
      .imem_rdata_i  (imem_rdata),
      .imem_raddr_o  (imem_raddr),
      .inst_o        (inst_o),
      .pc_o          (pc_o),
      .pc4_o         (pc4_o),
      .flush_o       (flush_o)
   );

   // Program RAM
   inst_mem u_inst_mem (
      .clk     (clk),
      .we_i    (imem_we),
      .waddr_i (imem_waddr),
      .wdata_i (imem_wdata),
      .raddr_i (imem_raddr),
      .rdata_o (imem_rdata)
   );

   assign loading_o = load_active;

endmodule

// File: hdl/inst_mem.sv
`timescale 1ns/1ps

module inst_mem (
   input  logic                          clk,
   // Loader write port
   input  logic                          we_i,
   input  logic [fetch_pkg::IMEM_AW-1:0] waddr_i,
   input  logic [fetch_pkg::XLEN-1:0]    wdata_i,
   // Fetch read port
   input  logic [fetch_pkg::IMEM_AW-1:0] raddr_i,
   output logic [fetch_pkg::XLEN-1:0]    rdata_o
);

   import fetch_pkg::*;

   logic [XLEN-1:0] mem [2**IMEM_AW];

   // Zeroed image at start of simulation
   initial begin
      for (int i = 0; i < 2**IMEM_AW; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
      // Write-first on a same-address clash
      if (we_i && (waddr_i == raddr_i)) begin
         rdata_o <= wdata_i;
      end else begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

// File: hdl/fetch_core.sv
`timescale 1ns/1ps

module fetch_core (
   input  logic                          clk,
   input  logic                          rstn,
   // Hazard stall from the pipeline
   input  logic                          pause_i,
   // Loader holds fetch at the reset PC
   input  logic                          load_active_i,
   // Redirect decision
   input  fetch_pkg::pc_sel_e            pc_sel_i,
   input  logic [fetch_pkg::XLEN-1:0]    target_i,
   // Program RAM read port
   input  logic [fetch_pkg::XLEN-1:0]    imem_rdata_i,
   output logic [fetch_pkg::IMEM_AW-1:0] imem_raddr_o,
   // To decode
   output logic [fetch_pkg::XLEN-1:0]    inst_o,
   output logic [fetch_pkg::XLEN-1:0]    pc_o,
   output logic [fetch_pkg::XLEN-1:0]    pc4_o,
   output logic                          flush_o
);

   import fetch_pkg::*;

   logic [XLEN-1:0] pc_q;
   logic [XLEN-1:0] pc_plus4;
   logic [XLEN-1:0] next_pc;
   logic            redirect;
   // Read data matches pc_q
   logic            rd_valid_q;

   assign pc_plus4 = pc_q + 32'd4;
   assign redirect = (pc_sel_i != PC_SEQ);

   ///////////////////////////////
   // Next PC
   ///////////////////////////////

   // Load first, then redirect, then pause, then sequential
   always_comb begin
      if (load_active_i) begin
         next_pc = RESET_PC;
      end else if (redirect) begin
         // Redirect overrides a pause
         next_pc = target_i;
      end else if (pause_i) begin
         next_pc = pc_q;
      end else begin
         next_pc = pc_plus4;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         pc_q <= RESET_PC;
      end else begin
         pc_q <= next_pc;
      end
   end

   // First registered read after reset is not yet aligned
   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= 1'b1;
      end
   end

   ///////////////////////////////
   // Memory and outputs
   ///////////////////////////////

   // Word address of the PC loaded on the next edge
   assign imem_raddr_o = next_pc[IMEM_AW+1:2];

   // No-op while loading or before the first read lands
   assign inst_o = (load_active_i || !rd_valid_q) ? NOP_INST : imem_rdata_i;

   assign pc_o  = pc_q;
   assign pc4_o = pc_plus4;

   // Kill younger stages on a taken redirect
   assign flush_o = redirect && !load_active_i;

endmodule

// File: hdl/prog_loader.sv
`timescale 1ns/1ps

module prog_loader (
   input  logic                          clk,
   input  logic                          rstn,
   // Upgrade port, sampled on clk
   input  logic                          upg_rst_i,
   input  logic                          upg_wen_i,
   input  logic                          upg_done_i,
   input  logic [fetch_pkg::IMEM_AW-1:0] upg_adr_i,
   input  logic [fetch_pkg::XLEN-1:0]    upg_dat_i,
   // Core hold
   output logic                          load_active_o,
   // Program RAM write port
   output logic                          imem_we_o,
   output logic [fetch_pkg::IMEM_AW-1:0] imem_waddr_o,
   output logic [fetch_pkg::XLEN-1:0]    imem_wdata_o
);

   import fetch_pkg::*;

   loader_state_e state_q;
   loader_state_e state_d;

   logic               we_q;
   logic [IMEM_AW-1:0] adr_q;
   logic [XLEN-1:0]    dat_q;

   ///////////////////////////////
   // Mode FSM
   ///////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         // Enter load when upgrade reset drops and no done is pending
         LD_RUN: begin
            if (!upg_rst_i && !upg_done_i) begin
               state_d = LD_LOAD;
            end
         end
         // Leave on done or on a fresh upgrade reset
         LD_LOAD: begin
            if (upg_done_i || upg_rst_i) begin
               state_d = LD_RUN;
            end
         end
         default: state_d = LD_RUN;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q <= LD_RUN;
      end else begin
         state_q <= state_d;
      end
   end

   ///////////////////////////////
   // Write path
   ///////////////////////////////

   // Strobe accepted only in load mode
   always_ff @(posedge clk) begin
      if (!rstn) begin
         we_q <= 1'b0;
      end else begin
         we_q <= (state_q == LD_LOAD) && upg_wen_i;
      end
   end

   // Address and data follow the strobe by one cycle
   always_ff @(posedge clk) begin
      if (upg_wen_i) begin
         adr_q <= upg_adr_i;
         dat_q <= upg_dat_i;
      end
   end

   assign load_active_o = (state_q == LD_LOAD);
   assign imem_we_o     = we_q;
   assign imem_waddr_o  = adr_q;
   assign imem_wdata_o  = dat_q;

endmodule

// File: hdl/pc_redirect.sv
`timescale 1ns/1ps

module pc_redirect (
   // Control from the EX/MEM register
   input  logic                        branch_i,
   input  logic                        zero_i,
   input  logic                        jump_i,
   input  logic                        jalr_i,
   // Operands from the EX/MEM register
   input  logic [fetch_pkg::XLEN-1:0]  alu_result_i,
   input  logic [fetch_pkg::XLEN-1:0]  imm32_i,
   input  logic [fetch_pkg::XLEN-1:0]  mem_pc_i,
   // Decision to the fetch core
   output fetch_pkg::pc_sel_e          pc_sel_o,
   output logic [fetch_pkg::XLEN-1:0]  target_o
);

   import fetch_pkg::*;

   // PC-relative target
   logic [XLEN-1:0] rel_target;

   // Branch and jump share one adder
   assign rel_target = mem_pc_i + imm32_i;

   // Priority resolve
   // Taken branch wins over jump, jump wins over jalr
   always_comb begin
      if (branch_i && zero_i) begin
         pc_sel_o = PC_BRANCH;
      end else if (jump_i) begin
         pc_sel_o = PC_JUMP;
      end else if (jalr_i) begin
         pc_sel_o = PC_JALR;
      end else begin
         pc_sel_o = PC_SEQ;
      end
   end

   // Register jump takes the ALU sum
   // All other sources use the relative target
   assign target_o = (pc_sel_o == PC_JALR) ? alu_result_i : rel_target;

endmodule

// File: hdl/fetch_pkg.sv
package fetch_pkg;

   ///////////////////////////////
   // Sizes and constants
   ///////////////////////////////

   // Datapath and PC width
   localparam int XLEN = 32;

   // Word address bits of the program RAM
   localparam int IMEM_AW = 14;

   // Fetch restarts here after reset or a program load
   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

   // addi x0, x0, 0
   localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

   ///////////////////////////////
   // Encodings
   ///////////////////////////////

   // Next-PC source
   typedef enum logic [1:0] {
      PC_SEQ    = 2'd0,
      PC_BRANCH = 2'd1,
      PC_JUMP   = 2'd2,
      PC_JALR   = 2'd3
   } pc_sel_e;

   // Upgrade loader modes
   typedef enum logic {
      LD_RUN  = 1'b0,
      LD_LOAD = 1'b1
   } loader_state_e;

endpackage
